// ==== design/aer_pkg.sv ====
// Shared definitions for the pixel event readout
// Address width, event word, Wishbone request and response structs,
// register map and arbiter state enum
`default_nettype none

package aer_pkg;

    localparam int ADDR_W = 4;                        // Row or column address bits

    typedef struct packed {
        logic [ADDR_W-1:0] row_addr;                  // Upper nibble of the word
        logic [ADDR_W-1:0] col_addr;
    } aer_event_t;

    typedef struct packed {
        logic        cyc;                             // Bus cycle in progress
        logic        stb;                             // Strobe for this access
        logic        we;
        logic [1:0]  adr;                             // Word address
        logic [31:0] dat;                             // Write data
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;                             // Read data, valid with ack
    } wb_rsp_t;

    localparam logic [1:0] REG_EVENT  = 2'd0;         // Pops one event word
    localparam logic [1:0] REG_STATUS = 2'd1;         // Count and empty flag

    typedef enum logic [1:0] {
        IDLE,
        ROW_SEL,
        COL_SCAN
    } arb_state_t;

endpackage

`default_nettype wire

// ==== design/pixel_event_latch.sv ====
// Per-pixel pending register for the sensor array
// Event pulses set a bit, arbiter grants clear it, a new event wins over a grant
`default_nettype none

module pixel_event_latch #(
    parameter int ROWS = 4,
    parameter int COLS = 8
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [ROWS-1:0][COLS-1:0] event_i,    // Single-cycle pulses from pixels
    input  logic [ROWS-1:0][COLS-1:0] grant_i,    // One-hot or zero from arbiter
    output logic [ROWS-1:0][COLS-1:0] pending_o
);

    logic [ROWS-1:0][COLS-1:0] pending_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pending_q <= '0;                          // No pixel waiting
        end
        else
        begin
            // Set over clear, repeats on a waiting pixel merge into one bit
            pending_q <= event_i | (pending_q & ~grant_i);
        end
    end

    assign pending_o = pending_q;

    // A grant must always land on a pixel that is waiting
    grant_on_pending_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (grant_i & ~pending_q) == '0
    ) else $error("grant to a pixel with no pending event");

endmodule

`default_nettype wire

// ==== design/round_robin_picker.sv ====
// Round-robin priority picker with a rotating pointer
// Combinational one-hot grant and index, pointer moves past the winner on advance
`default_nettype none

module round_robin_picker #(
    parameter int N = 4
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [N-1:0]               req_i,
    input  logic                       advance_i,       // Consume the current winner
    output logic [N-1:0]               gnt_o,
    output logic [aer_pkg::ADDR_W-1:0] idx_o
);

    localparam int AW = aer_pkg::ADDR_W;

    logic [AW-1:0] ptr_q;                               // Index with highest priority

    always_comb
    begin : pick
        logic found;
        int   pos;
        found = 1'b0;
        gnt_o = '0;
        idx_o = '0;
        for (int k = 0; k < N; k++)
        begin
            pos = (int'(ptr_q) + k) % N;                // Walk from pointer, wrap
            if (!found && req_i[pos])
            begin
                found      = 1'b1;                      // First hit wins
                gnt_o[pos] = 1'b1;
                idx_o      = AW'(pos);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q <= '0;                                // Index 0 first after reset
        end
        else if (advance_i && (|req_i))
        begin
            if (int'(idx_o) == N - 1)
                ptr_q <= '0;                            // Wrap past the top
            else
                ptr_q <= idx_o + 1'b1;
        end
    end

    onehot_gnt_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o) && ((|req_i) || (gnt_o == '0))
    ) else $error("picker grant not one-hot or granted without request");

endmodule

`default_nettype wire

// ==== design/row_col_arbiter.sv ====
// Row-then-column arbiter for the pending pixel array
// FSM picks a row round-robin, then grants its columns one per cycle
// and forms the event word pushed into the FIFO
`default_nettype none

module row_col_arbiter #(
    parameter int ROWS = 4,
    parameter int COLS = 8
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [ROWS-1:0][COLS-1:0] pending_i,
    input  logic                      fifo_full_i,  // Back-pressure from FIFO
    output logic [ROWS-1:0][COLS-1:0] grant_o,
    output logic                      push_o,
    output aer_pkg::aer_event_t       push_data_o
);

    localparam int AW = aer_pkg::ADDR_W;

    aer_pkg::arb_state_t state_q;
    aer_pkg::arb_state_t state_d;

    logic [ROWS-1:0] row_req;                       // Any pixel waiting per row
    logic [ROWS-1:0] row_gnt;
    logic [AW-1:0]   row_idx;
    logic [AW-1:0]   row_q;                         // Locked row address
    logic [COLS-1:0] col_req;                       // Pending bits of locked row
    logic [COLS-1:0] col_gnt;
    logic [AW-1:0]   col_idx;
    logic            row_adv;
    logic            scan_go;                       // Column grant this cycle

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
            row_req[r] = |pending_i[r];             // OR each row
    end

    always_comb
    begin
        col_req = '0;
        for (int r = 0; r < ROWS; r++)
        begin
            if (AW'(r) == row_q)
                col_req = pending_i[r];             // Mux out the locked row
        end
    end

    assign row_adv = (state_q == aer_pkg::ROW_SEL) && (|row_gnt);
    assign scan_go = (state_q == aer_pkg::COL_SCAN) && (|col_gnt) && !fifo_full_i;

    always_comb
    begin
        state_d = state_q;                          // Hold by default
        case (state_q)
            aer_pkg::IDLE:
            begin
                if (|row_req)
                    state_d = aer_pkg::ROW_SEL;
            end
            aer_pkg::ROW_SEL:
            begin
                if (|row_gnt)
                    state_d = aer_pkg::COL_SCAN;   // Row locked this cycle
                else
                    state_d = aer_pkg::IDLE;
            end
            aer_pkg::COL_SCAN:
            begin
                if (col_req == '0)                  // Row drained
                    state_d = (|row_req) ? aer_pkg::ROW_SEL : aer_pkg::IDLE;
            end
            default:
                state_d = aer_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= aer_pkg::IDLE;
            row_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (row_adv)
                row_q <= row_idx;                   // Lock the chosen row
        end
    end

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
                grant_o[r][c] = scan_go && (AW'(r) == row_q) && col_gnt[c];
        end
    end

    assign push_o               = scan_go;          // Push with the grant
    assign push_data_o.row_addr = row_q;
    assign push_data_o.col_addr = col_idx;

    round_robin_picker #(.N(ROWS)) rows_rr (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (row_req),
        .advance_i (row_adv),                       // Moves on each row choice
        .gnt_o     (row_gnt),
        .idx_o     (row_idx)
    );

    round_robin_picker #(.N(COLS)) cols_rr (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (col_req),
        .advance_i (scan_go),                       // Moves on each column grant
        .gnt_o     (col_gnt),
        .idx_o     (col_idx)
    );

    no_push_when_full_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        push_o |-> !fifo_full_i
    ) else $error("push while FIFO full");

    grant_with_push_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (grant_o != '0) == push_o
    ) else $error("grant and push out of step");

endmodule

`default_nettype wire

// ==== design/event_fifo.sv ====
// Synchronous FIFO of event words
// Circular buffer with occupancy count and full and empty flags
`default_nettype none

module event_fifo #(
    parameter int DEPTH = 8                          // Power of two
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         push_i,
    input  aer_pkg::aer_event_t          push_data_i,
    input  logic                         pop_i,
    output aer_pkg::aer_event_t          head_o,
    output logic                         full_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    aer_pkg::aer_event_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                do_push;
    logic                do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem[wr_ptr_q] <= push_data_i;            // Storage, no reset
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;         // Wraps at DEPTH
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;         // Both or neither
            endcase
        end
    end

    assign head_o  = mem[rd_ptr_q];                  // Oldest word
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign count_o = count_q;

    no_overflow_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(pop_i && empty_o) && !(push_i && full_o)
    ) else $error("FIFO pop when empty or push when full");

endmodule

`default_nettype wire

// ==== design/wb_event_port.sv ====
// Wishbone classic slave for draining event words
// Registered ack, event register pops the FIFO, status register reports count
`default_nettype none

module wb_event_port #(
    parameter int DEPTH = 8                         // Sizes count_i
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  aer_pkg::wb_req_t            wb_req_i,
    output aer_pkg::wb_rsp_t            wb_rsp_o,
    input  aer_pkg::aer_event_t         head_i,
    input  logic                        empty_i,
    input  logic [$clog2(DEPTH+1)-1:0]  count_i,
    output logic                        pop_o
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic        req;
    logic        req_q;                             // Access seen last cycle
    logic        new_req;                           // First cycle of a strobe
    logic        ack_q;
    logic [31:0] rd_dat;
    logic [31:0] dat_q;

    assign req     = wb_req_i.cyc && wb_req_i.stb;
    assign new_req = req && !req_q;
    assign pop_o   = new_req && !wb_req_i.we && (wb_req_i.adr == aer_pkg::REG_EVENT) &&
                     !empty_i;

    always_comb
    begin
        rd_dat = '0;
        case (wb_req_i.adr)
            aer_pkg::REG_EVENT:
            begin
                if (!empty_i)
                begin
                    rd_dat[31]  = 1'b1;             // Valid
                    rd_dat[7:0] = head_i;
                end
            end
            aer_pkg::REG_STATUS:
            begin
                rd_dat[16]        = empty_i;
                rd_dat[CNT_W-1:0] = count_i;
            end
            default: rd_dat = '0;                   // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end
        else
        begin
            req_q <= req;
            ack_q <= new_req;                       // One pulse per strobe
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (new_req)
            dat_q <= wb_req_i.we ? 32'h0 : rd_dat;  // Writes are dropped
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;

endmodule

`default_nettype wire

// ==== design/aer_readout.sv ====
// Top level of the pixel event readout path
// Event latch, row/column arbiter, event FIFO and Wishbone port
`default_nettype none

module aer_readout #(
    parameter int ROWS       = 4,
    parameter int COLS       = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [ROWS-1:0][COLS-1:0] pix_event_i,
    input  aer_pkg::wb_req_t          wb_req_i,
    output aer_pkg::wb_rsp_t          wb_rsp_o
);

    logic [ROWS-1:0][COLS-1:0]          pending;
    logic [ROWS-1:0][COLS-1:0]          grant;
    logic                               push;
    aer_pkg::aer_event_t                push_data;
    logic                               fifo_full;
    logic                               fifo_empty;
    logic                               pop;
    aer_pkg::aer_event_t                head;
    logic [$clog2(FIFO_DEPTH+1)-1:0]    count;

    pixel_event_latch #(.ROWS(ROWS), .COLS(COLS)) latch0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .event_i   (pix_event_i),
        .grant_i   (grant),
        .pending_o (pending)
    );

    row_col_arbiter #(.ROWS(ROWS), .COLS(COLS)) arb0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pending_i   (pending),
        .fifo_full_i (fifo_full),
        .grant_o     (grant),
        .push_o      (push),
        .push_data_o (push_data)
    );

    event_fifo #(.DEPTH(FIFO_DEPTH)) fifo0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .count_o     (count)
    );

    wb_event_port #(.DEPTH(FIFO_DEPTH)) port0 (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .head_i   (head),
        .empty_i  (fifo_empty),
        .count_i  (count),
        .pop_o    (pop)
    );

endmodule

`default_nettype wire

// ==== dv/aer_readout_tb.sv ====
// Directed testbench for the pixel event readout
// Clock, reset, pixel and Wishbone tasks, value check, six tests, watchdog
`default_nettype none

module aer_readout_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS          = 4;
    localparam int COLS          = 8;
    localparam int FIFO_DEPTH    = 8;
    localparam int NPIX          = ROWS * COLS;          // One mask bit per pixel
    localparam int RESET_CYC     = 5;
    localparam int ACK_WAIT      = 8;                    // Cycles allowed for an ack
    localparam int ACCESS_CYC    = ACK_WAIT + 3;         // Worst case per bus access
    localparam int POLL_MAX      = 30;
    localparam int DRAIN_MAX     = 60;
    localparam int RAND_ROUNDS   = 4;
    localparam int TEST_ACCESSES = 2 * POLL_MAX + DRAIN_MAX + 6;   // Bound per test or round
    localparam int WATCHDOG_CYC  = RESET_CYC + (5 + RAND_ROUNDS) * TEST_ACCESSES * ACCESS_CYC
                                   + 100;
    localparam logic [31:0] STATUS_MASK  = 32'h0001_FFFF;  // Empty flag and count
    localparam logic [31:0] STATUS_EMPTY = 32'h0001_0000;

    logic                      clk_i;
    logic                      reset_i;
    logic [ROWS-1:0][COLS-1:0] pix_event;
    aer_pkg::wb_req_t          wb_req;
    aer_pkg::wb_rsp_t          wb_rsp;
    int                        errors;
    logic [31:0]               rng_state;

    aer_readout #(.ROWS(ROWS), .COLS(COLS), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pix_event_i (pix_event),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;                       // 10 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [NPIX-1:0] pixel_bit(input int row, input int col);
        return NPIX'(1) << (row * COLS + col);           // Row-major, as the packed port
    endfunction

    // Event register layout: valid at bit 31, row and column nibbles at 7:0
    function automatic logic [31:0] event_word(input int row, input int col);
        return {1'b1, 23'd0, 4'(row), 4'(col)};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        waited = 0;
        rdat   = '0;
        @(posedge clk_i);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdat;
        @(negedge clk_i);                                // Sample away from the edge
        while (!wb_rsp.ack && waited < ACK_WAIT)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (wb_rsp.ack)
            rdat = wb_rsp.dat;
        else
        begin
            $display("Bus access to register %0d got no ack", adr);
            errors++;
        end
        @(posedge clk_i);
        wb_req <= '0;                                    // Drop strobe, next access is new
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic pulse_pixels(input logic [NPIX-1:0] mask);
        @(posedge clk_i);
        pix_event <= mask;
        @(posedge clk_i);
        pix_event <= '0;                                 // Single-cycle pulse
    endtask

    task automatic poll_count(input string name, input int exp_cnt, output logic [31:0] status);
        int polls;
        polls = 1;
        read_reg(aer_pkg::REG_STATUS, status);
        while (status[15:0] != 16'(exp_cnt) && polls < POLL_MAX)
        begin
            read_reg(aer_pkg::REG_STATUS, status);
            polls++;
        end
        if (status[15:0] != 16'(exp_cnt))
        begin
            $display("%s: status count never reached %0d", name, exp_cnt);
            errors++;
        end
    endtask

    // Reads until n valid words arrive, then compares the address set
    task automatic drain_events(input string name, input logic [NPIX-1:0] injected, input int n);
        logic [31:0]     rdat;
        logic [NPIX-1:0] seen;
        int              got;
        int              tries;
        int              row;
        int              col;
        seen  = '0;
        got   = 0;
        tries = 0;
        while (got < n && tries < DRAIN_MAX)
        begin
            read_reg(aer_pkg::REG_EVENT, rdat);
            tries++;
            if (rdat[31])
            begin
                row = int'(rdat[7:4]);
                col = int'(rdat[3:0]);
                got++;
                if (row >= ROWS || col >= COLS || seen[row * COLS + col])
                begin
                    $display("%s: unexpected or repeated event at row %0d col %0d",
                             name, row, col);
                    errors++;
                end
                else
                    seen[row * COLS + col] = 1'b1;
            end
        end
        check(name, 32'(injected), 32'(seen));
        poll_count(name, 0, rdat);
        check(name, STATUS_EMPTY, rdat & STATUS_MASK);
    endtask

    task automatic empty_read();
        logic [31:0] rdat;
        read_reg(aer_pkg::REG_STATUS, rdat);
        check("empty_read status", STATUS_EMPTY, rdat & STATUS_MASK);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("empty_read valid", 32'd0, 32'(rdat[31]));
    endtask

    // Column pointer is still at 0 from reset, so lowest column first
    task automatic column_order();
        logic [31:0] rdat;
        pulse_pixels(pixel_bit(2, 5) | pixel_bit(2, 1) | pixel_bit(2, 3));
        poll_count("column_order", 3, rdat);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("column_order first", event_word(2, 1), rdat);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("column_order second", event_word(2, 3), rdat);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("column_order third", event_word(2, 5), rdat);
        poll_count("column_order", 0, rdat);
    endtask

    task automatic row_rotation();
        logic [31:0] rdat;
        @(posedge clk_i);
        pix_event <= pixel_bit(1, 0);
        @(posedge clk_i);
        pix_event <= pixel_bit(1, 0);                    // Repeat while pending, merges
        @(posedge clk_i);
        pix_event <= pixel_bit(3, 4);                    // Pending only after row 1 is locked
        @(posedge clk_i);
        pix_event <= '0;
        poll_count("row_rotation", 2, rdat);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("row_rotation first", event_word(1, 0), rdat);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("row_rotation second", event_word(3, 4), rdat);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("row_rotation after drain", 32'd0, 32'(rdat[31]));
    endtask

    task automatic back_pressure();
        logic [31:0]     rdat;
        logic [NPIX-1:0] mask;
        mask = 32'h8421_C3A5;                            // 12 pixels over all rows
        pulse_pixels(mask);
        poll_count("back_pressure fill", FIFO_DEPTH, rdat);
        repeat (20) @(posedge clk_i);                    // Arbiter stalls on a full FIFO
        read_reg(aer_pkg::REG_STATUS, rdat);
        check("back_pressure saturate", 32'(FIFO_DEPTH), rdat & STATUS_MASK);
        drain_events("back_pressure drain", mask, $countones(mask));
    endtask

    task automatic random_sets();
        logic [NPIX-1:0] mask;
        for (int r = 0; r < RAND_ROUNDS; r++)
        begin
            rng_state = xorshift32(rng_state);
            mask      = rng_state;
            if (mask == '0)
                mask = pixel_bit(0, 0);                  // Never an empty round
            pulse_pixels(mask);
            drain_events($sformatf("random_sets round %0d", r), mask, $countones(mask));
        end
    endtask

    task automatic bus_writes();
        logic [31:0] rdat;
        pulse_pixels(pixel_bit(0, 7));
        poll_count("bus_writes", 1, rdat);
        bus_access(1'b1, aer_pkg::REG_EVENT, 32'hDEAD_BEEF, rdat);
        read_reg(aer_pkg::REG_STATUS, rdat);
        check("bus_writes status", 32'h0000_0001, rdat & STATUS_MASK);
        read_reg(aer_pkg::REG_EVENT, rdat);
        check("bus_writes event", event_word(0, 7), rdat);
        poll_count("bus_writes", 0, rdat);
    endtask

    initial
    begin
        reset_i   = 1'b1;
        pix_event = '0;
        wb_req    = '0;
        errors    = 0;
        rng_state = 32'd59568;
        repeat (RESET_CYC) @(posedge clk_i);
        reset_i <= 1'b0;
        empty_read();
        column_order();
        row_rotation();
        back_pressure();
        random_sets();
        bus_writes();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== aer_readout.f ====
design/aer_pkg.sv
design/pixel_event_latch.sv
design/round_robin_picker.sv
design/row_col_arbiter.sv
design/event_fifo.sv
design/wb_event_port.sv
design/aer_readout.sv
dv/aer_readout_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= aer_readout_tb
FILELIST  ?= aer_readout.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
